//--- cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int WORD_W      = 32;
    localparam int N_WAYS      = 2;
    localparam int N_SETS      = 64;
    localparam int BLOCK_WORDS = 2;
    localparam int SET_BITS    = $clog2(N_SETS);       // 6
    localparam int BLOCK_BITS  = $clog2(BLOCK_WORDS);  // 1
    localparam int TAG_BITS    = WORD_W - SET_BITS - BLOCK_BITS - 2;  // 23

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [3:0]          byte_en_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic                way_t;

    localparam word_t NONCACHE_START = 32'h8000_0000;  // uncached I/O space from here up

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        set_idx_t              idx;
        logic [BLOCK_BITS-1:0] blk;
        logic [1:0]            byte_off;
    } decoded_addr_t;

    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [TAG_BITS-1:0]          tag;
        word_t [BLOCK_WORDS-1:0]      data;
    } cache_frame_t;

    // one sram row holds every way of a set
    typedef struct packed {
        cache_frame_t [N_WAYS-1:0] frames;
    } cache_set_t;

    // byte enable to bit lanes, odd patterns act as a full word
    function automatic word_t lane_mask(input byte_en_t be);
        case (be)
            4'b0001: lane_mask = 32'h0000_00ff;
            4'b0010: lane_mask = 32'h0000_ff00;
            4'b0100: lane_mask = 32'h00ff_0000;
            4'b1000: lane_mask = 32'hff00_0000;
            4'b0011: lane_mask = 32'h0000_ffff;
            4'b1100: lane_mask = 32'hffff_0000;
            default: lane_mask = 32'hffff_ffff;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,        // hits and pass-through served here
        FETCH,
        WRITEBACK,
        FLUSH_SCAN,  // next set, or done
        FLUSH_WAY,
        FLUSH_WB
    } ctrl_state_e;

    typedef enum logic [2:0] {
        REQ_NONE,
        REQ_HIT_READ,
        REQ_HIT_WRITE,
        REQ_PASS,
        REQ_MISS_CLEAN,
        REQ_MISS_DIRTY
    } req_kind_e;

endpackage

`default_nettype wire

//--- cache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_sram
    import cache_geom_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  set_idx_t   sel,
    input  logic       wen,
    input  cache_set_t wrow,
    input  cache_set_t wmask,
    output cache_set_t rrow
);

    cache_set_t rows [N_SETS];

    assign rrow = rows[sel];  // async read, the lookup sees the row in the same cycle

    // mask bit set means keep the stored bit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                rows[i] <= '0;
            end
        end else if (wen) begin
            rows[sel] <= (rows[sel] & wmask) | (wrow & ~wmask);
        end
    end

    // the controller never strobes a write that changes nothing
    a_no_empty_write: assert property (
        @(posedge CLK) disable iff (!nRST)
        wen |-> (wmask != '1)
    );

endmodule

`default_nettype wire

//--- cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lookup
    import cache_geom_pkg::*, cache_ctrl_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  word_t               addr,
    input  logic                ren,
    input  logic                wen,
    input  logic                flushing,
    input  cache_set_t          rrow,
    input  logic                touch,
    output req_kind_e           kind,
    output way_t                hit_way,
    output way_t                victim_way,
    output logic [TAG_BITS-1:0] victim_tag,
    output word_t               hit_word
);

    decoded_addr_t     da;
    logic [N_WAYS-1:0] way_match;
    logic [N_SETS-1:0] last_used;  // most recently used way, per set
    cache_frame_t      victim;

    assign da = decoded_addr_t'(addr);

    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            way_match[w] = rrow.frames[w].valid && (rrow.frames[w].tag == da.tag);
        end
    end

    assign hit_way    = way_match[1];  // two ways only, so way 1 matching or not
    assign victim_way = ~last_used[da.idx];
    assign victim     = rrow.frames[victim_way];
    assign victim_tag = victim.tag;
    assign hit_word   = rrow.frames[hit_way].data[da.blk];

    always_comb begin
        if (flushing || !(ren || wen)) begin
            kind = REQ_NONE;
        end else if (addr >= NONCACHE_START) begin
            kind = REQ_PASS;
        end else if (|way_match) begin
            kind = wen ? REQ_HIT_WRITE : REQ_HIT_READ;
        end else if (victim.valid && victim.dirty) begin
            kind = REQ_MISS_DIRTY;
        end else begin
            kind = REQ_MISS_CLEAN;
        end
    end

    // replacement bits follow the hit way at each completed hit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[da.idx] <= hit_way;
        end
    end

    // a tag lives in at most one way of its set, fetch never duplicates it
    a_single_hit: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(way_match[0] && way_match[1])
    );

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_geom_pkg::*, cache_ctrl_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    input  req_kind_e           kind,
    input  way_t                hit_way,
    input  way_t                victim_way,
    input  logic [TAG_BITS-1:0] victim_tag,
    input  word_t               hit_word,
    input  cache_set_t          rrow,
    input  word_t               proc_addr,
    input  word_t               proc_wdata,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  byte_en_t            proc_byte_en,
    input  word_t               mem_rdata,
    input  logic                mem_busy,
    output word_t               proc_rdata,
    output logic                proc_busy,
    output logic                flush_done,
    output logic                flushing,
    output logic                touch,
    output logic                mem_ren,
    output logic                mem_wen,
    output word_t               mem_addr,
    output word_t               mem_wdata,
    output byte_en_t            mem_byte_en,
    output set_idx_t            sram_sel,
    output logic                sram_wen,
    output cache_set_t          sram_wrow,
    output cache_set_t          sram_wmask
);

    ctrl_state_e           state, next_state;
    logic [BLOCK_BITS:0]   word_cnt, next_word;  // msb set means block done
    logic [1:0]            way_cnt, next_way;    // msb set means set done
    logic [SET_BITS:0]     set_cnt, next_set;    // msb set means flush done
    word_t                 base_addr, next_base;
    decoded_addr_t         req;
    logic [BLOCK_BITS-1:0] word_idx;
    way_t                  fway;
    logic                  word_done;
    word_t                 blk_addr;

    assign req       = decoded_addr_t'(proc_addr);
    assign word_idx  = word_cnt[BLOCK_BITS-1:0];
    assign word_done = word_cnt[BLOCK_BITS];
    assign fway      = way_cnt[0];
    assign blk_addr  = {base_addr[WORD_W-1:BLOCK_BITS+2], word_idx, 2'b00};

    assign flushing = flush || (state inside {FLUSH_SCAN, FLUSH_WAY, FLUSH_WB});
    assign sram_sel = flushing ? set_cnt[SET_BITS-1:0] : req.idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            way_cnt  <= '0;
            set_cnt  <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word;
            way_cnt  <= next_way;
            set_cnt  <= next_set;
        end
    end

    always_ff @(posedge CLK) begin
        base_addr <= next_base;
    end

    always_comb begin
        next_state  = state;
        next_word   = word_cnt;
        next_way    = way_cnt;
        next_set    = set_cnt;
        next_base   = base_addr;
        proc_busy   = 1'b1;
        proc_rdata  = hit_word;
        touch       = 1'b0;
        flush_done  = 1'b0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = blk_addr;
        mem_wdata   = '0;
        mem_byte_en = '1;  // block transfers move whole words
        sram_wen    = 1'b0;
        sram_wrow   = '0;
        sram_wmask  = '1;

        case (state)
            IDLE: begin
                case (kind)
                    REQ_HIT_READ: begin
                        proc_busy = 1'b0;
                        touch     = 1'b1;
                    end
                    REQ_HIT_WRITE: begin
                        proc_busy = 1'b0;
                        touch     = 1'b1;
                        sram_wen  = 1'b1;
                        sram_wrow.frames[hit_way].data[req.blk]  = proc_wdata;
                        sram_wmask.frames[hit_way].data[req.blk] = ~lane_mask(proc_byte_en);
                        sram_wrow.frames[hit_way].dirty  = 1'b1;
                        sram_wmask.frames[hit_way].dirty = 1'b0;
                    end
                    REQ_PASS: begin
                        mem_ren     = proc_ren;
                        mem_wen     = proc_wen;
                        mem_addr    = proc_addr;
                        mem_byte_en = proc_byte_en;
                        mem_wdata   = proc_wdata & lane_mask(proc_byte_en);  // idle lanes zero
                        proc_busy   = mem_busy;
                        proc_rdata  = mem_rdata;
                    end
                    REQ_MISS_CLEAN: begin
                        next_base  = {req.tag, req.idx, {BLOCK_BITS{1'b0}}, 2'b00};
                        next_word  = '0;
                        next_state = FETCH;
                    end
                    REQ_MISS_DIRTY: begin
                        next_base  = {victim_tag, req.idx, {BLOCK_BITS{1'b0}}, 2'b00};
                        next_word  = '0;
                        next_state = WRITEBACK;
                    end
                    default: ;
                endcase
                if (flush) begin
                    next_state = FLUSH_SCAN;
                end
            end

            FETCH: begin
                if (word_done) begin
                    // install the tag; the request then hits in IDLE
                    sram_wen = 1'b1;
                    sram_wrow.frames[victim_way].valid  = 1'b1;
                    sram_wrow.frames[victim_way].tag    = req.tag;
                    sram_wmask.frames[victim_way].valid = 1'b0;
                    sram_wmask.frames[victim_way].dirty = 1'b0;
                    sram_wmask.frames[victim_way].tag   = '0;
                    next_word  = '0;
                    next_state = IDLE;
                end else begin
                    mem_ren = 1'b1;
                    if (!mem_busy) begin
                        sram_wen = 1'b1;
                        sram_wrow.frames[victim_way].data[word_idx]  = mem_rdata;
                        sram_wmask.frames[victim_way].data[word_idx] = '0;
                        next_word = word_cnt + 1'b1;
                    end
                end
            end

            WRITEBACK: begin
                if (word_done) begin
                    sram_wen = 1'b1;
                    sram_wmask.frames[victim_way].dirty = 1'b0;  // victim now clean
                    next_word  = '0;
                    next_base  = {req.tag, req.idx, {BLOCK_BITS{1'b0}}, 2'b00};
                    next_state = FETCH;
                end else begin
                    mem_wen   = 1'b1;
                    mem_wdata = rrow.frames[victim_way].data[word_idx];
                    if (!mem_busy) begin
                        next_word = word_cnt + 1'b1;
                    end
                end
            end

            FLUSH_SCAN: begin
                if (set_cnt[SET_BITS]) begin
                    flush_done = 1'b1;
                    next_set   = '0;
                    next_state = IDLE;
                end else begin
                    next_state = FLUSH_WAY;
                end
            end

            FLUSH_WAY: begin
                if (way_cnt[1]) begin
                    next_way   = '0;
                    next_set   = set_cnt + 1'b1;
                    next_state = FLUSH_SCAN;
                end else if (rrow.frames[fway].valid) begin
                    next_state = FLUSH_WB;
                end else begin
                    next_way = way_cnt + 1'b1;  // empty frame, skip
                end
            end

            FLUSH_WB: begin
                if (!rrow.frames[fway].dirty || word_done) begin
                    sram_wen = 1'b1;
                    sram_wmask.frames[fway] = '0;  // zero the whole frame
                    next_word  = '0;
                    next_way   = way_cnt + 1'b1;
                    next_state = FLUSH_WAY;
                end else begin
                    mem_wen   = 1'b1;
                    mem_addr  = {rrow.frames[fway].tag, set_cnt[SET_BITS-1:0], word_idx, 2'b00};
                    mem_wdata = rrow.frames[fway].data[word_idx];
                    if (!mem_busy) begin
                        next_word = word_cnt + 1'b1;
                    end
                end
            end

            default: next_state = IDLE;
        endcase
    end

    a_mem_one_dir: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen)
    );

endmodule

`default_nettype wire

//--- l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache
    import cache_geom_pkg::*, cache_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    output logic     flush_done,
    // processor side
    input  logic     proc_ren,
    input  logic     proc_wen,
    input  word_t    proc_addr,
    input  word_t    proc_wdata,
    input  byte_en_t proc_byte_en,
    output word_t    proc_rdata,
    output logic     proc_busy,
    // memory side
    output logic     mem_ren,
    output logic     mem_wen,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output byte_en_t mem_byte_en,
    input  word_t    mem_rdata,
    input  logic     mem_busy
);

    req_kind_e           kind;
    way_t                hit_way;
    way_t                victim_way;
    logic [TAG_BITS-1:0] victim_tag;
    word_t               hit_word;
    logic                flushing;
    logic                touch;
    set_idx_t            sram_sel;
    logic                sram_wen;
    cache_set_t          sram_wrow;
    cache_set_t          sram_wmask;
    cache_set_t          rrow;

    cache_lookup u_lookup (
        .CLK        (CLK),
        .nRST       (nRST),
        .addr       (proc_addr),
        .ren        (proc_ren),
        .wen        (proc_wen),
        .flushing   (flushing),
        .rrow       (rrow),
        .touch      (touch),
        .kind       (kind),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .victim_tag (victim_tag),
        .hit_word   (hit_word)
    );

    cache_ctrl u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .kind         (kind),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .hit_word     (hit_word),
        .rrow         (rrow),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_byte_en (proc_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .flush_done   (flush_done),
        .flushing     (flushing),
        .touch        (touch),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .sram_sel     (sram_sel),
        .sram_wen     (sram_wen),
        .sram_wrow    (sram_wrow),
        .sram_wmask   (sram_wmask)
    );

    cache_sram u_sram (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sram_sel),
        .wen   (sram_wen),
        .wrow  (sram_wrow),
        .wmask (sram_wmask),
        .rrow  (rrow)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import cache_geom_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  ren,
    input  logic  wen,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata,
    output logic  busy
);

    localparam int         DEPTH       = 1024;
    localparam logic [1:0] WAIT_CYCLES = 2'd2;  // busy cycles before the completing one
    localparam word_t      PATTERN     = 32'h5a5a_0000;

    word_t      mem [DEPTH];
    logic [9:0] idx;
    logic [1:0] wait_cnt;
    logic       active;

    assign idx    = addr[11:2];  // 4 KB window, upper address bits alias
    assign active = ren || wen;
    assign busy   = active && (wait_cnt < WAIT_CYCLES);
    assign rdata  = mem[idx];

    // each word starts as its own byte address xor the pattern
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = word_t'(i << 2) ^ PATTERN;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!busy) begin
            wait_cnt <= '0;  // idle or completing, next access waits again
        end else begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    // word-wide store, the cache already zeroes unused lanes
    always @(posedge CLK) begin
        if (wen && !busy) begin
            mem[idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- tb_l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache
    import cache_geom_pkg::*;
();

    localparam int          CLK_HALF       = 20;
    localparam int          DRIVE_DLY      = 2;
    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = 20000;  // a few thousand cycles of traffic, wide margin
    localparam int unsigned RAND_SEED      = 32'h6c251a31;
    localparam word_t       PATTERN        = 32'h5a5a_0000;
    localparam word_t       WH_ADDR        = 32'h0000_0108;  // set 0x21, word 0
    localparam byte_en_t    LEGAL_BE [7]   = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                               4'b0011, 4'b1100, 4'b1111};
    localparam word_t       FLUSH_ADDR [4] = '{32'h0000_0380, 32'h0000_0394,
                                               32'h0000_03a8, 32'h0000_03f0};

    logic     CLK;
    logic     nRST;
    logic     flush;
    logic     flush_done;
    logic     proc_ren;
    logic     proc_wen;
    word_t    proc_addr;
    word_t    proc_wdata;
    byte_en_t proc_byte_en;
    word_t    proc_rdata;
    logic     proc_busy;
    logic     mem_ren;
    logic     mem_wen;
    word_t    mem_addr;
    word_t    mem_wdata;
    byte_en_t mem_byte_en;
    word_t    mem_rdata;
    logic     mem_busy;

    int       n_checks;
    int       n_errors;
    int       cycle_cnt;
    word_t    wh_last;      // final value of the write-hit word, still dirty in the cache
    byte_en_t last_mem_be;  // byte enable of the latest memory bus cycle

    l1_cache DUT (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy)
    );

    tb_mem_model u_mem (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (mem_ren),
        .wen   (mem_wen),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata),
        .busy  (mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    always @(negedge CLK) begin
        if (mem_ren || mem_wen) begin
            last_mem_be = mem_byte_en;
        end
    end

    function automatic word_t mem_init_value(input word_t addr);
        return {20'h0, addr[11:2], 2'b00} ^ PATTERN;
    endfunction

    function automatic word_t peek(input word_t addr);
        return u_mem.mem[addr[11:2]];
    endfunction

    // each enabled byte lane takes the new byte
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input byte_en_t be);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (n_errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - errors_before);
        end
    endtask

    // holds the request until busy is low at a falling edge, the next rising edge completes it
    task automatic bus_access(input logic write, input word_t addr, input word_t wdata,
                              input byte_en_t be, output word_t rdata, output int mem_reads);
        @(posedge CLK);
        #DRIVE_DLY;
        proc_ren     = !write;
        proc_wen     = write;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = be;
        mem_reads    = 0;
        @(negedge CLK);
        while (proc_busy) begin
            mem_reads += int'(mem_ren);
            @(negedge CLK);
        end
        mem_reads += int'(mem_ren);  // pass-through reads finish with mem_ren still high
        rdata = proc_rdata;
        @(posedge CLK);
        #DRIVE_DLY;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic proc_read(input word_t addr, output word_t data, output int mem_reads);
        bus_access(1'b0, addr, '0, 4'b1111, data, mem_reads);
    endtask

    task automatic proc_write(input word_t addr, input word_t data, input byte_en_t be,
                              output int mem_reads);
        word_t unused_rdata;
        bus_access(1'b1, addr, data, be, unused_rdata, mem_reads);
    endtask

    task automatic test_reset();
        int e0;
        e0 = n_errors;
        @(negedge CLK);
        check_bit("mem_ren", mem_ren, 1'b0);
        check_bit("mem_wen", mem_wen, 1'b0);
        check_bit("flush_done", flush_done, 1'b0);
        check_bit("proc_busy", proc_busy, 1'b1);
        end_test("reset", e0);
    endtask

    task automatic test_read_miss_hit();
        word_t a;
        word_t d;
        int    reads;
        int    e0;
        e0 = n_errors;
        a  = 32'h0000_0010;
        proc_read(a, d, reads);
        check_word("proc_rdata", d, mem_init_value(a));
        check_bit("mem_ren", reads != 0, 1'b1);
        proc_read(a, d, reads);
        check_word("proc_rdata", d, mem_init_value(a));
        check_bit("mem_ren", reads != 0, 1'b0);
        proc_read(a + 32'd4, d, reads);  // other word of the fetched block
        check_word("proc_rdata", d, mem_init_value(a + 32'd4));
        check_bit("mem_ren", reads != 0, 1'b0);
        end_test("read_miss_hit", e0);
    endtask

    task automatic test_write_hit();
        word_t d;
        word_t wd;
        word_t exp;
        int    reads;
        int    e0;
        e0  = n_errors;
        exp = mem_init_value(WH_ADDR);
        proc_read(WH_ADDR, d, reads);
        for (int i = 0; i < 7; i++) begin
            wd = $urandom;
            proc_write(WH_ADDR, wd, LEGAL_BE[i], reads);
            check_bit("mem_ren", reads != 0, 1'b0);
            exp = merge_bytes(exp, wd, LEGAL_BE[i]);
            proc_read(WH_ADDR, d, reads);
            check_word("proc_rdata", d, exp);
        end
        wd = $urandom;
        proc_write(WH_ADDR, wd, 4'b0101, reads);  // odd pattern acts as full word
        exp = wd;
        proc_read(WH_ADDR, d, reads);
        check_word("proc_rdata", d, exp);
        check_word("mem", peek(WH_ADDR), mem_init_value(WH_ADDR));
        wh_last = exp;
        end_test("write_hit", e0);
    endtask

    task automatic test_replacement();
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t b_data;
        int    reads;
        int    e0;
        e0     = n_errors;
        a      = 32'h0000_0028;  // set 5, tags 0, 1 and 2
        b      = 32'h0000_0228;
        c      = 32'h0000_0428;
        b_data = $urandom;
        proc_read(a, d, reads);
        check_word("proc_rdata", d, mem_init_value(a));
        proc_write(b, b_data, 4'b1111, reads);
        check_bit("mem_ren", reads != 0, 1'b1);
        proc_read(b, d, reads);
        check_word("proc_rdata", d, b_data);
        proc_read(a, d, reads);
        check_bit("mem_ren", reads != 0, 1'b0);
        check_word("mem", peek(b), mem_init_value(b));
        proc_read(c, d, reads);  // b is least recent and dirty
        check_word("proc_rdata", d, mem_init_value(c));
        check_word("mem", peek(b), b_data);
        check_word("mem", peek(b + 32'd4), mem_init_value(b + 32'd4));
        proc_read(a, d, reads);
        check_word("proc_rdata", d, mem_init_value(a));
        check_bit("mem_ren", reads != 0, 1'b0);
        proc_read(b, d, reads);
        check_word("proc_rdata", d, b_data);
        check_bit("mem_ren", reads != 0, 1'b1);
        end_test("replacement", e0);
    endtask

    task automatic test_pass_through();
        word_t p0;
        word_t p1;
        word_t d;
        word_t wd;
        int    reads;
        int    e0;
        e0 = n_errors;
        p0 = NONCACHE_START + 32'h0000_0f00;
        p1 = NONCACHE_START + 32'h0000_0f04;
        wd = $urandom;
        proc_read(p0, d, reads);
        check_word("proc_rdata", d, mem_init_value(p0));
        check_bit("mem_ren", reads != 0, 1'b1);
        proc_write(p1, wd, 4'b1100, reads);
        check_be("mem_byte_en", last_mem_be, 4'b1100);
        check_word("mem", peek(p1), {wd[31:16], 16'h0000});
        proc_read(p1, d, reads);
        check_word("proc_rdata", d, {wd[31:16], 16'h0000});
        check_bit("mem_ren", reads != 0, 1'b1);
        proc_read(p0, d, reads);
        check_bit("mem_ren", reads != 0, 1'b1);
        end_test("pass_through", e0);
    endtask

    task automatic test_flush();
        word_t fdata [4];
        word_t d;
        int    reads;
        int    pulses;
        logic  done;
        int    e0;
        e0 = n_errors;
        for (int i = 0; i < 4; i++) begin
            fdata[i] = $urandom;
            proc_write(FLUSH_ADDR[i], fdata[i], 4'b1111, reads);
        end
        @(posedge CLK);
        #DRIVE_DLY;
        flush  = 1'b1;
        pulses = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge CLK);
            if (flush_done) begin
                pulses++;
                done = 1'b1;
            end
        end
        @(posedge CLK);
        #DRIVE_DLY;
        flush = 1'b0;
        repeat (3) begin
            @(negedge CLK);
            pulses += int'(flush_done);
        end
        if (pulses != 1) begin
            n_errors++;
            $display("error: flush_done pulsed %0d times instead of once", pulses);
        end
        for (int i = 0; i < 4; i++) begin
            check_word("mem", peek(FLUSH_ADDR[i]), fdata[i]);
        end
        check_word("mem", peek(WH_ADDR), wh_last);
        check_be("mem_byte_en", last_mem_be, 4'b1111);  // write-back moves whole words
        proc_read(FLUSH_ADDR[0], d, reads);
        check_word("proc_rdata", d, fdata[0]);
        check_bit("mem_ren", reads != 0, 1'b1);
        end_test("flush", e0);
    endtask

    initial begin
        n_checks     = 0;
        n_errors     = 0;
        wh_last      = '0;
        last_mem_be  = '0;
        nRST         = 1'b0;
        flush        = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DLY;
        nRST = 1'b1;

        test_reset();
        test_read_miss_hit();
        test_write_hit();
        test_replacement();
        test_pass_through();
        test_flush();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- l1_cache.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_sram.sv
cache_lookup.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_l1_cache
RTL_TOP   ?= l1_cache
FILELIST  ?= l1_cache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing
RTL_SRCS  ?= cache_geom_pkg.sv cache_ctrl_pkg.sv cache_sram.sv cache_lookup.sv \
             cache_ctrl.sv l1_cache.sv
TB_SRCS   ?= tb_mem_model.sv tb_l1_cache.sv
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
